/* include/bram_config.svh */
// Geometry of the dual-port block-RAM array and of one memory cell
`ifndef BRAM_CONFIG_SVH
`define BRAM_CONFIG_SVH

// One cell
`define BRAM_BIT_WIDTH 32    // Data bits per cell word
`define BRAM_WORDS     1024  // Words per cell

// Array of cells
`define NUM_PAR_BRAMS  2     // Cells side by side, widens the port
`define NUM_SER_BRAMS  4     // Rows of cells, deepens the address space

// Byte address per port, 4 rows x 1024 words x 4 bytes
`define ADDR_WIDTH     14

`endif

/* hw/bramPkg.sv */
// Vector types shared by the block-RAM array and its testbench
`include "bram_config.svh"

package bramPkg;

  // One cell
  typedef logic [`BRAM_BIT_WIDTH-1:0]   bramWordT;
  typedef logic [`BRAM_BIT_WIDTH/8-1:0] bramByteEnT;

  // Whole port, NUM_PAR_BRAMS cells wide
  typedef logic [`BRAM_BIT_WIDTH*`NUM_PAR_BRAMS-1:0]   arrDataT;
  typedef logic [`BRAM_BIT_WIDTH/8*`NUM_PAR_BRAMS-1:0] arrByteEnT;

  // Byte address as seen at a port
  typedef logic [`ADDR_WIDTH-1:0] byteAddrT;

  // Address split into a row and a word inside the row
  typedef logic [$clog2(`NUM_SER_BRAMS)-1:0] serIdxT;
  typedef logic [$clog2(`BRAM_WORDS)-1:0]    wordIdxT;

endpackage

/* hw/bramPortDecode.sv */
// Port address decoder, splits a byte address into row and word and steers byte enables
`timescale 1ns/1ps
`include "bram_config.svh"

module bramPortDecode (
  input  bramPkg::byteAddrT  addr,
  input  bramPkg::arrByteEnT wrEn,
  output bramPkg::serIdxT    serIdx,
  output bramPkg::wordIdxT   wordIdx,
  output bramPkg::arrByteEnT rowWrEn [`NUM_SER_BRAMS]
);
  import bramPkg::*;

  // Byte offset inside one cell word is dropped
  localparam int OFFS_W = $clog2(`BRAM_BIT_WIDTH / 8);
  localparam int WADDR_W = `ADDR_WIDTH - OFFS_W;

  logic [WADDR_W-1:0] wordAddr;

  assign wordAddr = addr[`ADDR_WIDTH-1:OFFS_W];  // Byte address / 4

  // Row is wordAddr / BRAM_WORDS, word is the remainder
  assign serIdx  = serIdxT'(wordAddr >> $bits(wordIdxT));
  assign wordIdx = wordAddr[$bits(wordIdxT)-1:0];

  // Enables reach the addressed row only, every other row sees zero
  always_comb begin
    for (int r = 0; r < `NUM_SER_BRAMS; r++) begin
      if (serIdx == serIdxT'(r)) begin
        rowWrEn[r] = wrEn;
      end else begin
        rowWrEn[r] = '0;
      end
    end
  end

endmodule

/* hw/bramCell.sv */
// Behavioural true dual-port memory cell with byte writes and write-first read registers
`timescale 1ns/1ps
`include "bram_config.svh"

module bramCell (
  input  logic                          A_PS,
  input  logic                          rstN,
  input  logic                          enA,
  input  logic                          enB,
  input  logic [`BRAM_BIT_WIDTH/8-1:0]  wrEnA,
  input  logic [`BRAM_BIT_WIDTH/8-1:0]  wrEnB,
  input  logic [$clog2(`BRAM_WORDS)-1:0] wordIdxA,
  input  logic [$clog2(`BRAM_WORDS)-1:0] wordIdxB,
  input  logic [`BRAM_BIT_WIDTH-1:0]    wrDataA,
  input  logic [`BRAM_BIT_WIDTH-1:0]    wrDataB,
  output logic [`BRAM_BIT_WIDTH-1:0]    rdDataA,
  output logic [`BRAM_BIT_WIDTH-1:0]    rdDataB
);

  localparam int BYTES = `BRAM_BIT_WIDTH / 8;

  logic [`BRAM_BIT_WIDTH-1:0] mem [`BRAM_WORDS];
  logic [`BRAM_BIT_WIDTH-1:0] mergedA, mergedB;  // Stored word with new bytes laid over

  // New word per port, old bytes kept where the enable is low
  always_comb begin
    mergedA = mem[wordIdxA];
    mergedB = mem[wordIdxB];
    for (int b = 0; b < BYTES; b++) begin
      if (wrEnA[b]) begin
        mergedA[8*b +: 8] = wrDataA[8*b +: 8];
      end
      if (wrEnB[b]) begin
        mergedB[8*b +: 8] = wrDataB[8*b +: 8];
      end
    end
  end

  // Storage, same-word writes from both ports are left undefined
  always_ff @(posedge A_PS) begin
    if (enA && (wrEnA != '0)) begin
      mem[wordIdxA] <= mergedA;
    end
    if (enB && (wrEnB != '0)) begin
      mem[wordIdxB] <= mergedB;
    end
  end

  // Write-first output registers, hold while idle
  always_ff @(posedge A_PS or negedge rstN) begin
    if (!rstN) begin
      rdDataA <= '0;
      rdDataB <= '0;
    end else begin
      if (enA) begin
        rdDataA <= mergedA;  // Shows the word after this access
      end
      if (enB) begin
        rdDataB <= mergedB;
      end
    end
  end

endmodule

/* hw/bramReadMux.sv */
// Read-side row mux, steered by the row index captured on the last enabled edge
`timescale 1ns/1ps
`include "bram_config.svh"

module bramReadMux (
  input  logic             A_PS,
  input  logic             rstN,
  input  logic             en,
  input  bramPkg::serIdxT  serIdx,
  input  bramPkg::arrDataT rowData [`NUM_SER_BRAMS],
  output bramPkg::arrDataT rdData
);
  import bramPkg::*;

  serIdxT selIdx;  // Row of the access now at the cell outputs

  // Captured with the same edge that loads the cell registers
  always_ff @(posedge A_PS or negedge rstN) begin
    if (!rstN) begin
      selIdx <= '0;
    end else if (en) begin
      selIdx <= serIdx;
    end
  end

  // Idle cells hold their registers, so the output holds with them
  assign rdData = rowData[selIdx];

endmodule

/* hw/tdpBramArray.sv */
// True dual-port block-RAM array, a grid of cells with per-port decode and row mux
`timescale 1ns/1ps
`include "bram_config.svh"

module tdpBramArray (
  input  logic               A_PS,
  input  logic               rstN,
  input  logic               enA,
  input  logic               enB,
  input  bramPkg::arrByteEnT wrEnA,
  input  bramPkg::arrByteEnT wrEnB,
  input  bramPkg::byteAddrT  addrA,
  input  bramPkg::byteAddrT  addrB,
  input  bramPkg::arrDataT   wrDataA,
  input  bramPkg::arrDataT   wrDataB,
  output bramPkg::arrDataT   rdDataA,
  output bramPkg::arrDataT   rdDataB
);
  import bramPkg::*;

  localparam int CELL_W     = $bits(bramWordT);
  localparam int CELL_BYTES = $bits(bramByteEnT);
  localparam int ARR_W      = $bits(arrDataT);
  localparam int ARR_BYTES  = $bits(arrByteEnT);

  serIdxT    serIdxA, serIdxB;
  wordIdxT   wordIdxA, wordIdxB;
  arrByteEnT rowWrEnA [`NUM_SER_BRAMS];  // Only the addressed row sees enables
  arrByteEnT rowWrEnB [`NUM_SER_BRAMS];
  arrDataT   rowRdA [`NUM_SER_BRAMS];    // Read word of every row, per port
  arrDataT   rowRdB [`NUM_SER_BRAMS];

  // Address resolution per port
  bramPortDecode decodeA_i (
    .addr    (addrA),
    .wrEn    (wrEnA),
    .serIdx  (serIdxA),
    .wordIdx (wordIdxA),
    .rowWrEn (rowWrEnA)
  );

  bramPortDecode decodeB_i (
    .addr    (addrB),
    .wrEn    (wrEnB),
    .serIdx  (serIdxB),
    .wordIdx (wordIdxB),
    .rowWrEn (rowWrEnB)
  );

  // Cell grid, rows by address, columns by data slice
  for (genvar s = 0; s < `NUM_SER_BRAMS; s++) begin : gRow
    for (genvar p = 0; p < `NUM_PAR_BRAMS; p++) begin : gCol
      // Cell 0 holds the most significant slice
      localparam int BIT_LO  = ARR_W - CELL_W * (p + 1);
      localparam int BYTE_LO = ARR_BYTES - CELL_BYTES * (p + 1);

      bramCell cell_i (
        .A_PS     (A_PS),
        .rstN     (rstN),
        .enA      (enA),
        .enB      (enB),
        .wrEnA    (rowWrEnA[s][BYTE_LO +: CELL_BYTES]),
        .wrEnB    (rowWrEnB[s][BYTE_LO +: CELL_BYTES]),
        .wordIdxA (wordIdxA),
        .wordIdxB (wordIdxB),
        .wrDataA  (wrDataA[BIT_LO +: CELL_W]),
        .wrDataB  (wrDataB[BIT_LO +: CELL_W]),
        .rdDataA  (rowRdA[s][BIT_LO +: CELL_W]),
        .rdDataB  (rowRdB[s][BIT_LO +: CELL_W])
      );
    end
  end

  // Row select on the read side, one cycle behind the address
  bramReadMux muxA_i (
    .A_PS    (A_PS),
    .rstN    (rstN),
    .en      (enA),
    .serIdx  (serIdxA),
    .rowData (rowRdA),
    .rdData  (rdDataA)
  );

  bramReadMux muxB_i (
    .A_PS    (A_PS),
    .rstN    (rstN),
    .en      (enB),
    .serIdx  (serIdxB),
    .rowData (rowRdB),
    .rdData  (rdDataB)
  );

endmodule

/* verification/tdpBramArray_assert.sv */
// Bound assertions on row decode, reset values and idle hold of the block-RAM array
`timescale 1ns/1ps
`include "bram_config.svh"

module tdpBramArrayAssert (
  input logic              A_PS,
  input logic              rstN,
  input logic              enA,
  input logic              enB,
  input bramPkg::byteAddrT addrA,
  input bramPkg::byteAddrT addrB,
  input bramPkg::serIdxT   serIdxA,
  input bramPkg::serIdxT   serIdxB,
  input bramPkg::arrDataT  rdDataA,
  input bramPkg::arrDataT  rdDataB
);

  // Bytes held by one row of cells
  localparam int ROW_BYTES = `BRAM_WORDS * (`BRAM_BIT_WIDTH / 8);

  int assertErrs = 0;  // Failed assertion count

  // Row steered by the decoder is the byte address over the row size
  rowDecodeA: assert property (@(posedge A_PS) disable iff (!rstN)
      enA |-> (int'(serIdxA) == int'(addrA) / ROW_BYTES))
    else begin
      $error("port A row index %0d does not match addr %h", serIdxA, addrA);
      assertErrs++;
    end

  rowDecodeB: assert property (@(posedge A_PS) disable iff (!rstN)
      enB |-> (int'(serIdxB) == int'(addrB) / ROW_BYTES))
    else begin
      $error("port B row index %0d does not match addr %h", serIdxB, addrB);
      assertErrs++;
    end

  // Output registers clear as soon as reset is applied
  resetZero: assert property (@(posedge A_PS) !rstN |-> (rdDataA == '0 && rdDataB == '0))
    else begin
      $error("read data not zero during reset, A %h B %h", rdDataA, rdDataB);
      assertErrs++;
    end

  holdA: assert property (@(posedge A_PS) disable iff (!rstN) !enA |=> $stable(rdDataA))
    else begin
      $error("rdDataA changed after an idle edge");
      assertErrs++;
    end

  holdB: assert property (@(posedge A_PS) disable iff (!rstN) !enB |=> $stable(rdDataB))
    else begin
      $error("rdDataB changed after an idle edge");
      assertErrs++;
    end

endmodule

bind tdpBramArray tdpBramArrayAssert tdpBramArrayAssert_i (
  .A_PS    (A_PS),
  .rstN    (rstN),
  .enA     (enA),
  .enB     (enB),
  .addrA   (addrA),
  .addrB   (addrB),
  .serIdxA (serIdxA),
  .serIdxB (serIdxB),
  .rdDataA (rdDataA),
  .rdDataB (rdDataB)
);

/* verification/tdpBramArrayTb.sv */
// Testbench for the dual-port block-RAM array, replays access vectors and checks read data
`timescale 1ns/1ps
`include "bram_config.svh"

module tdpBramArrayTb;
  import bramPkg::*;

  localparam int RST_CYCLES = 4;
  localparam int MAX_VEC    = 64;
  localparam int FIELDS     = 6;  // Values per vector line, port first
  localparam int F_EN       = 1;
  localparam int F_BE       = 2;
  localparam int F_ADDR     = 3;
  localparam int F_WDATA    = 4;
  localparam int F_EXP      = 5;
  localparam int BE_W       = $bits(arrByteEnT);
  localparam int AD_W       = $bits(byteAddrT);
  localparam int unsigned SEED = 32'ha9f8;

  logic      A_PS;
  logic      rstN;
  logic      enA;
  logic      enB;
  arrByteEnT wrEnA;
  arrByteEnT wrEnB;
  byteAddrT  addrA;
  byteAddrT  addrB;
  arrDataT   wrDataA;
  arrDataT   wrDataB;
  arrDataT   rdDataA;
  arrDataT   rdDataB;

  arrDataT vecMem [MAX_VEC*FIELDS];  // Flat vector table
  int      numVec;
  bit      loaded;
  int      dataErrs;
  int      idleErrs;
  int      setupErrs;

  // Access sampled on the last edge, checked on the following negedge
  bit      pendValid;
  logic    pendPort;
  logic    pendEn;
  arrDataT pendExp;

  tdpBramArray tdpBramArray_i (
    .A_PS    (A_PS),
    .rstN    (rstN),
    .enA     (enA),
    .enB     (enB),
    .wrEnA   (wrEnA),
    .wrEnB   (wrEnB),
    .addrA   (addrA),
    .addrB   (addrB),
    .wrDataA (wrDataA),
    .wrDataB (wrDataB),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB)
  );

  initial A_PS = 1'b0;
  always #2 A_PS = ~A_PS;  // 4 ns period

  task automatic checkData(input string name, input arrDataT got, input arrDataT exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      dataErrs++;
    end
  endtask

  task automatic checkIdle(input string name, input arrDataT got, input arrDataT held);
    if (got !== held) begin
      $display("FAIL %s changed while idle, got %h held %h", name, got, held);
      idleErrs++;
    end
  endtask

  function automatic bit isRead(input int idx);
    int b;
    b = idx * FIELDS;
    return (vecMem[b+F_EN][0] == 1'b1) && (vecMem[b+F_BE][BE_W-1:0] == '0);
  endfunction

  // Reads on one port in a row go out on consecutive edges
  function automatic bit backToBack(input int idx);
    int b;
    b = idx * FIELDS;
    if (idx + 1 >= numVec) begin
      return 1'b0;
    end
    return (vecMem[b][0] == vecMem[b+FIELDS][0]) && isRead(idx) && isRead(idx + 1);
  endfunction

  task automatic driveIdle();
    enA   <= 1'b0;
    enB   <= 1'b0;
    wrEnA <= '0;
    wrEnB <= '0;
  endtask

  task automatic driveVector(input int idx);
    int b;
    b = idx * FIELDS;
    if (vecMem[b][0] == 1'b0) begin
      enA     <= vecMem[b+F_EN][0];
      wrEnA   <= vecMem[b+F_BE][BE_W-1:0];
      addrA   <= vecMem[b+F_ADDR][AD_W-1:0];
      wrDataA <= vecMem[b+F_WDATA];
      enB     <= 1'b0;
      wrEnB   <= '0;
    end else begin
      enB     <= vecMem[b+F_EN][0];
      wrEnB   <= vecMem[b+F_BE][BE_W-1:0];
      addrB   <= vecMem[b+F_ADDR][AD_W-1:0];
      wrDataB <= vecMem[b+F_WDATA];
      enA     <= 1'b0;
      wrEnA   <= '0;
    end
  endtask

  task automatic checkPending();
    if (pendValid) begin
      if (pendPort == 1'b0) begin
        if (pendEn) checkData("rdDataA", rdDataA, pendExp);
        else checkIdle("rdDataA", rdDataA, pendExp);
      end else begin
        if (pendEn) checkData("rdDataB", rdDataB, pendExp);
        else checkIdle("rdDataB", rdDataB, pendExp);
      end
    end
  endtask

  // One clock, idx below zero leaves both ports idle
  task automatic stepCycle(input int idx);
    int b;
    b = idx * FIELDS;
    @(posedge A_PS);
    if (idx >= 0) driveVector(idx);
    else driveIdle();
    @(negedge A_PS);
    checkPending();
    pendValid = (idx >= 0);
    if (idx >= 0) begin
      pendPort = vecMem[b][0];
      pendEn   = vecMem[b+F_EN][0];
      pendExp  = vecMem[b+F_EXP];
    end
  endtask

  task automatic report();
    int total;
    total = dataErrs + idleErrs + setupErrs + tdpBramArray_i.tdpBramArrayAssert_i.assertErrs;
    $display("Errors: data %0d, idle %0d, setup %0d, assertions %0d", dataErrs, idleErrs,
             setupErrs, tdpBramArray_i.tdpBramArrayAssert_i.assertErrs);
    if (total == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  initial begin
    int gap;
    rstN      = 1'b1;
    enA       = 1'b0;
    enB       = 1'b0;
    wrEnA     = '0;
    wrEnB     = '0;
    addrA     = '0;
    addrB     = '0;
    wrDataA   = '0;
    wrDataB   = '0;
    dataErrs  = 0;
    idleErrs  = 0;
    setupErrs = 0;
    pendValid = 1'b0;
    void'($urandom(SEED));
    for (int k = 0; k < MAX_VEC * FIELDS; k++) begin
      vecMem[k] = '1;  // Port field above 1 marks the end of the table
    end
    $readmemh("verification/tdpBramArray_vectors.txt", vecMem);
    numVec = 0;
    while (numVec < MAX_VEC && vecMem[numVec*FIELDS] < 64'd2) begin
      numVec++;
    end
    loaded = 1'b1;
    if (numVec == 0) begin
      $display("No vectors could be read from the vector file");
      setupErrs++;
    end else begin
      #1 rstN = 1'b0;
      repeat (RST_CYCLES) @(posedge A_PS);
      rstN <= 1'b1;
      @(negedge A_PS);
      checkData("rdDataA", rdDataA, '0);  // Cleared by reset
      checkData("rdDataB", rdDataB, '0);
      for (int i = 0; i < numVec; i++) begin
        stepCycle(i);
        if (!backToBack(i)) begin
          gap = $urandom % 3;
          repeat (gap) stepCycle(-1);
        end
      end
      stepCycle(-1);  // Last result
    end
    report();
  end

  // Watchdog sized from the vector count
  initial begin
    wait (loaded);
    repeat (numVec * 8 + RST_CYCLES) @(posedge A_PS);
    $display("Timeout, vector replay did not finish in %0d cycles", numVec * 8 + RST_CYCLES);
    $display("sim failed");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
hw/bramPkg.sv
hw/bramPortDecode.sv
hw/bramCell.sv
hw/bramReadMux.sv
hw/tdpBramArray.sv
verification/tdpBramArray_assert.sv
verification/tdpBramArrayTb.sv

/* run.sh */
#!/bin/sh
# Build the dual-port block-RAM testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tdpBramArrayTb -f verilog.f -o simTdpBramArray
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Raised error limit keeps the run going after an assertion fires
out=$(./obj_dir/simTdpBramArray +verilator+error+limit+1000 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

/* verification/tdpBramArray_vectors.txt */
// port(0=A 1=B) en byteEn addr wrData expRdData, all hex
// en=0 lines expect the port to keep showing expRdData
0 1 FF 0010 1122334455667788 1122334455667788
1 1 00 0010 0000000000000000 1122334455667788
1 1 FF 1020 A5A5A5A55A5A5A5A A5A5A5A55A5A5A5A
0 1 00 1020 0000000000000000 A5A5A5A55A5A5A5A
0 1 0F 0010 DEADBEEFCAFEF00D 11223344CAFEF00D
1 1 00 0010 0000000000000000 11223344CAFEF00D
1 1 C3 1020 0102030405060708 0102A5A55A5A0708
0 1 00 1020 0000000000000000 0102A5A55A5A0708
0 1 FF 0100 1000000000000001 1000000000000001
0 1 FF 1100 2000000000000002 2000000000000002
0 1 FF 2100 3000000000000003 3000000000000003
0 1 FF 3100 4000000000000004 4000000000000004
1 1 00 3100 0000000000000000 4000000000000004
1 1 00 0100 0000000000000000 1000000000000001
1 1 00 2100 0000000000000000 3000000000000003
1 1 00 1100 0000000000000000 2000000000000002
1 0 00 0000 0000000000000000 2000000000000002
0 1 00 0013 0000000000000000 11223344CAFEF00D
1 1 30 2102 FFEEDDCCBBAA9988 3000DDCC00000003
0 0 00 0000 0000000000000000 11223344CAFEF00D
0 1 00 2100 0000000000000000 3000DDCC00000003
1 0 00 0000 0000000000000000 3000DDCC00000003
